//--- common/phyPkg.sv
`default_nettype none

package phyPkg;

    //////////////////////////////////////////////////////////////////////
    // Bus geometry and DRAM timing
    //////////////////////////////////////////////////////////////////////

    // DQ width, one beat per clk
    localparam int dataWidth = 64;
    // Beats per burst on the DQ bus
    localparam int burstBeats = 4;
    // Read latency, issue to first captured beat
    localparam int tCl = 16;
    // Write latency, issue to timed burst
    localparam int tCwl = 12;
    // Issued commands remembered per direction
    localparam int reqWindowDepth = 8;
    // Whole bursts each beat FIFO can hold
    localparam int fifoBursts = 4;

    // Derived widths
    localparam int beatCntW = $clog2(burstBeats);
    localparam int fifoBeats = fifoBursts * burstBeats;
    localparam int fifoPtrW = $clog2(fifoBeats);
    localparam int fifoFillW = $clog2(fifoBeats + 1);
    localparam int burstCntW = $clog2(fifoBursts + 1);
    localparam int windowPtrW = $clog2(reqWindowDepth);
    // Timed writes may run ahead of stored data, up to a full window
    localparam int timedCntW = $clog2(reqWindowDepth + 1);

    //////////////////////////////////////////////////////////////////////
    // Address and beat types
    //////////////////////////////////////////////////////////////////////

    // Packed DRAM address, 33 bits
    typedef struct packed {
        logic [1:0]  rank;
        logic [3:0]  bank;
        logic [15:0] row;
        logic [9:0]  column;
        logic        autoPrecharge;
    } memAddr_t;

    // Scheduler issue strobe with its address
    typedef struct packed {
        logic     valid;
        memAddr_t addr;
    } cmdIssue_t;

    // Auto-precharge acknowledge toward the rank FSM
    typedef struct packed {
        logic     valid;
        memAddr_t addr;
    } apAck_t;

    // Beat toward the read buffer, tag is the request rank
    typedef struct packed {
        logic [dataWidth-1:0] data;
        logic [1:0]           tag;
        logic                 valid;
        logic                 last;
    } readBeat_t;

    // Beat from the write buffer
    typedef struct packed {
        logic [dataWidth-1:0] data;
        logic                 valid;
        logic                 last;
    } writeBeat_t;

    // DQ drive toward the DRAM, oe replaces the tri-state
    typedef struct packed {
        logic [dataWidth-1:0] data;
        logic                 oe;
    } dqDrive_t;

    // Read capture FSM
    typedef enum logic {capIdle, capBurst} capState_t;

    // Write launch FSM
    typedef enum logic {launchIdle, launchBurst} launchState_t;

endpackage

`default_nettype wire

//--- hdl/requestWindow.sv
`default_nettype none

module requestWindow (
    input  logic              clk,
    input  logic              rst,
    input  phyPkg::cmdIssue_t push,
    input  logic              pop,
    output phyPkg::memAddr_t  headAddr
);
    import phyPkg::*;

    // Address storage, written on issue only
    memAddr_t ring [reqWindowDepth];
    // One valid bit per slot
    logic [reqWindowDepth-1:0] entryValid;
    logic [windowPtrW-1:0] wrPtr;
    logic [windowPtrW-1:0] rdPtr;
    logic popOk;

    // Stray completions with an empty head are ignored
    assign popOk = pop && entryValid[rdPtr];

    always_ff @(posedge clk) begin
        if (push.valid) begin
            ring[wrPtr] <= push.addr;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Pointers and slot valids
    //////////////////////////////////////////////////////////////////////

    // Depth is a power of two so both pointers wrap on their own
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            entryValid <= '0;
        end else begin
            if (popOk) begin
                entryValid[rdPtr] <= 1'b0;
                rdPtr <= rdPtr + 1'b1;
            end
            // Push last so a new entry wins a shared slot
            if (push.valid) begin
                entryValid[wrPtr] <= 1'b1;
                wrPtr <= wrPtr + 1'b1;
            end
        end
    end

    // Oldest outstanding request
    assign headAddr = ring[rdPtr];

endmodule

`default_nettype wire

//--- readPath/readCapture.sv
`default_nettype none

module readCapture (
    input  logic                         clk,
    input  logic                         rst,
    input  phyPkg::cmdIssue_t            issue,
    input  logic [phyPkg::dataWidth-1:0] dqIn,
    output phyPkg::readBeat_t            readOut,
    output phyPkg::apAck_t               readAp,
    output logic                         readReady,
    output logic                         readBusy
);
    import phyPkg::*;

    // One bit per issued read in flight, bit tCl-2 starts a capture
    logic [tCl-2:0] latLine;
    capState_t capState;
    logic [beatCntW-1:0] beatCnt;
    logic captureNow;
    logic burstDone;
    memAddr_t headAddr;

    // Tagged beat FIFO toward the read buffer
    readBeat_t fifoMem [fifoBeats];
    logic [fifoPtrW-1:0] fifoWrPtr;
    logic [fifoPtrW-1:0] fifoRdPtr;
    logic [fifoFillW-1:0] fifoFill;
    logic [burstCntW-1:0] burstCnt;
    logic fifoEmit;
    logic outValid;
    readBeat_t outBeat;
    logic apValid;
    memAddr_t apAddr;

    //////////////////////////////////////////////////////////////////////
    // tCL delay line and capture window
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            latLine <= '0;
        end else begin
            latLine <= {latLine[tCl-3:0], issue.valid};
        end
    end

    assign captureNow = (capState == capBurst);
    assign burstDone = captureNow && (beatCnt == beatCntW'(burstBeats - 1));

    // A new start on the last beat restarts the window back to back
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            capState <= capIdle;
            beatCnt <= '0;
        end else if (latLine[tCl-2]) begin
            capState <= capBurst;
            beatCnt <= '0;
        end else if (burstDone) begin
            capState <= capIdle;
            beatCnt <= '0;
        end else if (captureNow) begin
            beatCnt <= beatCnt + 1'b1;
        end
    end

    // Head entry is the burst being captured
    requestWindow window (
        .clk      (clk),
        .rst      (rst),
        .push     (issue),
        .pop      (burstDone),
        .headAddr (headAddr)
    );

    //////////////////////////////////////////////////////////////////////
    // Beat FIFO, drained every cycle while not empty
    //////////////////////////////////////////////////////////////////////

    assign fifoEmit = (fifoFill != '0);

    always_ff @(posedge clk) begin
        if (captureNow) begin
            fifoMem[fifoWrPtr] <= '{data: dqIn, tag: headAddr.rank, valid: 1'b1,
                                   last: burstDone};
        end
        if (fifoEmit) begin
            outBeat <= fifoMem[fifoRdPtr];
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            fifoWrPtr <= '0;
            fifoRdPtr <= '0;
            fifoFill <= '0;
            outValid <= 1'b0;
        end else begin
            if (captureNow) begin
                fifoWrPtr <= fifoWrPtr + 1'b1;
            end
            if (fifoEmit) begin
                fifoRdPtr <= fifoRdPtr + 1'b1;
            end
            case ({captureNow, fifoEmit})
                2'b10:   fifoFill <= fifoFill + 1'b1;
                2'b01:   fifoFill <= fifoFill - 1'b1;
                default: fifoFill <= fifoFill;
            endcase
            outValid <= fifoEmit;
        end
    end

    assign readOut = '{data: outBeat.data, tag: outBeat.tag, valid: outValid,
                       last: outValid && outBeat.last};

    // Whole bursts held, in on last capture, out on last emitted beat
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            burstCnt <= '0;
        end else begin
            case ({burstDone, readOut.last})
                2'b10:   burstCnt <= burstCnt + 1'b1;
                2'b01:   burstCnt <= burstCnt - 1'b1;
                default: burstCnt <= burstCnt;
            endcase
        end
    end

    assign readReady = (burstCnt < burstCntW'(fifoBursts - 1));

    // Acknowledge every burst, rank FSM checks the flag itself
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            apValid <= 1'b0;
        end else begin
            apValid <= burstDone;
        end
    end

    always_ff @(posedge clk) begin
        if (burstDone) begin
            apAddr <= headAddr;
        end
    end

    assign readAp = '{valid: apValid, addr: apAddr};
    assign readBusy = (|latLine) || captureNow;

endmodule

`default_nettype wire

//--- writePath/writeLaunch.sv
`default_nettype none

module writeLaunch (
    input  logic               clk,
    input  logic               rst,
    input  phyPkg::cmdIssue_t  issue,
    input  phyPkg::writeBeat_t writeIn,
    output phyPkg::dqDrive_t   writeBeatOut,
    output phyPkg::apAck_t     writeAp,
    output logic               writeAck,
    output logic               writeReady,
    output logic               writeBusy
);
    import phyPkg::*;

    // Beat FIFO from the write buffer
    logic [dataWidth-1:0] fifoMem [fifoBeats];
    logic [fifoPtrW-1:0] fifoWrPtr;
    logic [fifoPtrW-1:0] fifoRdPtr;
    // Complete bursts held in the FIFO
    logic [burstCntW-1:0] storedCnt;
    logic burstIn;

    // Top bit of the line marks a write whose tCWL has elapsed
    logic [tCwl-1:0] latLine;
    logic [timedCntW-1:0] timedCnt;
    launchState_t launchState;
    logic [beatCntW-1:0] beatCnt;
    logic launching;
    logic launchDone;
    memAddr_t headAddr;
    logic apValid;
    memAddr_t apAddr;

    //////////////////////////////////////////////////////////////////////
    // Write beat FIFO and stored-burst count
    //////////////////////////////////////////////////////////////////////

    assign burstIn = writeIn.valid && writeIn.last;

    always_ff @(posedge clk) begin
        if (writeIn.valid) begin
            fifoMem[fifoWrPtr] <= writeIn.data;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            fifoWrPtr <= '0;
            fifoRdPtr <= '0;
            storedCnt <= '0;
        end else begin
            if (writeIn.valid) begin
                fifoWrPtr <= fifoWrPtr + 1'b1;
            end
            if (launching) begin
                fifoRdPtr <= fifoRdPtr + 1'b1;
            end
            case ({burstIn, launchDone})
                2'b10:   storedCnt <= storedCnt + 1'b1;
                2'b01:   storedCnt <= storedCnt - 1'b1;
                default: storedCnt <= storedCnt;
            endcase
        end
    end

    // Buffer must hold off once three bursts wait here
    assign writeReady = (storedCnt < burstCntW'(fifoBursts - 1));

    //////////////////////////////////////////////////////////////////////
    // tCWL delay line and timed count
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            latLine <= '0;
            timedCnt <= '0;
        end else begin
            latLine <= {latLine[tCwl-2:0], issue.valid};
            case ({latLine[tCwl-1], launchDone})
                2'b10:   timedCnt <= timedCnt + 1'b1;
                2'b01:   timedCnt <= timedCnt - 1'b1;
                default: timedCnt <= timedCnt;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Burst launch
    //////////////////////////////////////////////////////////////////////

    assign launching = (launchState == launchBurst);
    assign launchDone = launching && (beatCnt == beatCntW'(burstBeats - 1));

    // Always back to idle after a burst, so oe drops between bursts
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            launchState <= launchIdle;
            beatCnt <= '0;
        end else if (launching) begin
            if (launchDone) begin
                launchState <= launchIdle;
            end
            beatCnt <= beatCnt + 1'b1;
        end else if ((timedCnt != '0) && (storedCnt != '0)) begin
            launchState <= launchBurst;
            beatCnt <= '0;
        end
    end

    // Registered one stage later by the bus driver
    assign writeBeatOut = '{data: fifoMem[fifoRdPtr], oe: launching};

    requestWindow window (
        .clk      (clk),
        .rst      (rst),
        .push     (issue),
        .pop      (launchDone),
        .headAddr (headAddr)
    );

    // Lines up with the last beat on the registered DQ bus
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            apValid <= 1'b0;
        end else begin
            apValid <= launchDone;
        end
    end

    always_ff @(posedge clk) begin
        if (launchDone) begin
            apAddr <= headAddr;
        end
    end

    assign writeAck = apValid;
    assign writeAp = '{valid: apValid, addr: apAddr};
    // Pending timed writes count as busy too
    assign writeBusy = (|latLine) || launching || (timedCnt != '0);

endmodule

`default_nettype wire

//--- hdl/dqBusDriver.sv
`default_nettype none

module dqBusDriver (
    input  logic             clk,
    input  logic             rst,
    input  phyPkg::dqDrive_t writeBeatOut,
    input  logic             readBusy,
    input  logic             writeBusy,
    output phyPkg::dqDrive_t dqOut,
    output logic             modeReady
);
    import phyPkg::*;

    // Registered drive enable
    logic oeQ;
    // Registered drive data
    logic [dataWidth-1:0] dataQ;

    //////////////////////////////////////////////////////////////////////
    // DQ output stage
    //////////////////////////////////////////////////////////////////////

    // Beats launched into a read window never reach the pins
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            oeQ <= 1'b0;
        end else begin
            oeQ <= writeBeatOut.oe && !readBusy;
        end
    end

    // Data only moves with a launched beat
    always_ff @(posedge clk) begin
        if (writeBeatOut.oe) begin
            dataQ <= writeBeatOut.data;
        end
    end

    // Pins follow the registered stage directly
    assign dqOut = '{data: dataQ, oe: oeQ};

    // Channel can switch direction once nothing is in flight on DQ
    assign modeReady = !(readBusy || writeBusy || oeQ);

endmodule

`default_nettype wire

//--- hdl/phyController.sv
`default_nettype none

module phyController (
    input  logic                         clk,
    input  logic                         rst,
    // Scheduler issue strobes
    input  phyPkg::cmdIssue_t            readIssue,
    input  phyPkg::cmdIssue_t            writeIssue,
    // Write buffer side
    input  phyPkg::writeBeat_t           writeIn,
    output logic                         writeReady,
    output logic                         writeAck,
    // Read buffer side
    output phyPkg::readBeat_t            readOut,
    output logic                         readReady,
    // Auto-precharge acknowledges to the rank FSM
    output phyPkg::apAck_t               readAp,
    output phyPkg::apAck_t               writeAp,
    // DRAM DQ bus, split into in, out and enable
    input  logic [phyPkg::dataWidth-1:0] dqIn,
    output phyPkg::dqDrive_t             dqOut,
    // Channel mode transition
    output logic                         modeReady
);
    import phyPkg::*;

    logic readBusy;
    logic writeBusy;
    dqDrive_t writeBeatOut;

    //////////////////////////////////////////////////////////////////////
    // Read and write paths side by side, bus stage combines them
    //////////////////////////////////////////////////////////////////////

    readCapture readPath (
        .clk       (clk),
        .rst       (rst),
        .issue     (readIssue),
        .dqIn      (dqIn),
        .readOut   (readOut),
        .readAp    (readAp),
        .readReady (readReady),
        .readBusy  (readBusy)
    );

    writeLaunch writePath (
        .clk          (clk),
        .rst          (rst),
        .issue        (writeIssue),
        .writeIn      (writeIn),
        .writeBeatOut (writeBeatOut),
        .writeAp      (writeAp),
        .writeAck     (writeAck),
        .writeReady   (writeReady),
        .writeBusy    (writeBusy)
    );

    dqBusDriver busDriver (
        .clk          (clk),
        .rst          (rst),
        .writeBeatOut (writeBeatOut),
        .readBusy     (readBusy),
        .writeBusy    (writeBusy),
        .dqOut        (dqOut),
        .modeReady    (modeReady)
    );

endmodule

`default_nettype wire

//--- tests/phyController_props.sv
`default_nettype none

module phyControllerProps (
    input logic             clk,
    input logic             rst,
    input logic             readBusy,
    input logic             writeAck,
    input phyPkg::dqDrive_t dqOut,
    input phyPkg::apAck_t   readAp,
    input phyPkg::apAck_t   writeAp
);
    timeunit 1ns;
    timeprecision 1ps;

    //////////////////////////////////////////////////////////////////////
    // DQ bus and acknowledge rules
    //////////////////////////////////////////////////////////////////////

    // Reads own the bus while a capture is pending
    property oeIsolated;
        @(posedge clk) disable iff (!rst)
        !(dqOut.oe && readBusy);
    endproperty

    // One acknowledge per burst
    property readApSingle;
        @(posedge clk) disable iff (!rst)
        readAp.valid |=> !readAp.valid;
    endproperty

    property writeApSingle;
        @(posedge clk) disable iff (!rst)
        writeAp.valid |=> !writeAp.valid;
    endproperty

    // Ack rides the last beat, drive released right after
    property oeFallsAfterAck;
        @(posedge clk) disable iff (!rst)
        writeAck |=> !dqOut.oe;
    endproperty

    oeIsolatedChk: assert property (oeIsolated)
        else $error("DQ driven while a read capture is busy");
    readApSingleChk: assert property (readApSingle)
        else $error("readAp high in two consecutive cycles");
    writeApSingleChk: assert property (writeApSingle)
        else $error("writeAp high in two consecutive cycles");
    oeFallsAfterAckChk: assert property (oeFallsAfterAck)
        else $error("DQ still driven one cycle after writeAck");

endmodule

bind phyController phyControllerProps props (
    .clk      (clk),
    .rst      (rst),
    .readBusy (readBusy),
    .writeAck (writeAck),
    .dqOut    (dqOut),
    .readAp   (readAp),
    .writeAp  (writeAp)
);

`default_nettype wire

//--- tests/tbPhyController.sv
`default_nettype none

module tbPhyController;
    timeunit 1ns;
    timeprecision 1ps;
    import phyPkg::*;

    // Six tests of well under 200 cycles each, plus reset
    localparam int maxCycles = 2000;

    logic clk;
    logic rst;
    cmdIssue_t readIssue;
    cmdIssue_t writeIssue;
    writeBeat_t writeIn;
    logic [dataWidth-1:0] dqIn;
    readBeat_t readOut;
    apAck_t readAp;
    apAck_t writeAp;
    logic readReady;
    logic writeReady;
    logic writeAck;
    logic modeReady;
    dqDrive_t dqOut;

    int cycleCnt = 0;
    logic [31:0] lcgState = 32'h9b27_1b47;

    // Addresses issued by the current test, in issue order
    memAddr_t readAddrQ[$];
    memAddr_t writeAddrQ[$];
    // Expected streams
    readBeat_t expReadQ[$];
    logic [dataWidth-1:0] expDqQ[$];

    // Observed by the monitor
    readBeat_t readQ[$];
    memAddr_t readApQ[$];
    logic [dataWidth-1:0] dqQ[$];
    int runQ[$];
    int ackPosQ[$];
    memAddr_t writeApQ[$];
    int oeRun = 0;
    int readIssueCycle = -1;
    int writeIssueCycle = -1;
    int firstReadCycle = -1;
    int firstOeCycle = -1;
    logic issueSeen = 1'b0;
    logic prevReadAp = 1'b0;
    logic prevWriteAp = 1'b0;
    logic prevAck = 1'b0;

    phyController DUT (
        .clk        (clk),
        .rst        (rst),
        .readIssue  (readIssue),
        .writeIssue (writeIssue),
        .writeIn    (writeIn),
        .writeReady (writeReady),
        .writeAck   (writeAck),
        .readOut    (readOut),
        .readReady  (readReady),
        .readAp     (readAp),
        .writeAp    (writeAp),
        .dqIn       (dqIn),
        .dqOut      (dqOut),
        .modeReady  (modeReady)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycleCnt <= cycleCnt + 1;
    end

    always @(posedge clk) begin
        if (cycleCnt >= maxCycles) begin
            $display("Timeout: the run did not finish within %0d cycles", maxCycles);
            $display("Finished with errors");
            $fatal(1, "timeout");
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    task automatic compareValues(input string testName, input logic [63:0] expected,
                                 input logic [63:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s expected %0h actual %0h", testName, expected, actual);
            $display("Finished with errors");
            $fatal(1, "value mismatch in %s", testName);
        end
    endtask

    function automatic logic [31:0] lcgNext();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic logic [dataWidth-1:0] randData();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = lcgNext();
        lo = lcgNext();
        return {hi, lo};
    endfunction

    // Random address on a chosen rank
    function automatic memAddr_t randAddr(input logic [1:0] rank);
        logic [31:0] r;
        r = lcgNext();
        return '{rank: rank, bank: r[3:0], row: r[19:4], column: r[29:20],
                 autoPrecharge: r[30]};
    endfunction

    task automatic idleCycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic clearMonitor();
        expReadQ.delete();
        expDqQ.delete();
        readQ.delete();
        readApQ.delete();
        dqQ.delete();
        runQ.delete();
        ackPosQ.delete();
        writeApQ.delete();
        readIssueCycle = -1;
        writeIssueCycle = -1;
        firstReadCycle = -1;
        firstOeCycle = -1;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Monitor, samples on the falling edge once outputs have settled
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (rst) begin
            // Busy rises in the cycle right after an issue is sampled
            if (issueSeen) begin
                compareValues("modeReady after issue", 64'd0, 64'(modeReady));
            end
            issueSeen = readIssue.valid || writeIssue.valid;
            if (readIssue.valid && readIssueCycle < 0) begin
                readIssueCycle = cycleCnt;
            end
            if (writeIssue.valid && writeIssueCycle < 0) begin
                writeIssueCycle = cycleCnt;
            end
            if (readOut.valid) begin
                if (firstReadCycle < 0) begin
                    firstReadCycle = cycleCnt;
                end
                readQ.push_back(readOut);
            end
            if (readAp.valid) begin
                readApQ.push_back(readAp.addr);
            end
            // Bus rules, one burst of oe per launch
            compareValues("oe during read", 64'd0, 64'(dqOut.oe && DUT.readBusy));
            compareValues("readAp spacing", 64'd0, 64'(prevReadAp && readAp.valid));
            compareValues("writeAp spacing", 64'd0, 64'(prevWriteAp && writeAp.valid));
            if (prevAck) begin
                compareValues("oe after writeAck", 64'd0, 64'(dqOut.oe));
            end
            if (dqOut.oe) begin
                if (firstOeCycle < 0) begin
                    firstOeCycle = cycleCnt;
                end
                oeRun++;
                dqQ.push_back(dqOut.data);
            end else if (oeRun != 0) begin
                runQ.push_back(oeRun);
                oeRun = 0;
            end
            if (writeAck) begin
                compareValues("writeAp with writeAck", 64'd1, 64'(writeAp.valid));
                ackPosQ.push_back(dqOut.oe ? oeRun : 0);
                writeApQ.push_back(writeAp.addr);
            end
            prevReadAp = readAp.valid;
            prevWriteAp = writeAp.valid;
            prevAck = writeAck;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    // Issues reads burstBeats apart and feeds dqIn over the capture window
    task automatic readBursts(input string name, input int n);
        logic [dataWidth-1:0] beat;
        int total;
        int k;
        total = n * burstBeats;
        clearMonitor();
        for (int c = 0; c < tCl + total; c++) begin
            @(posedge clk);
            if ((c % burstBeats == 0) && (c / burstBeats < n)) begin
                readIssue <= '{valid: 1'b1, addr: readAddrQ[c / burstBeats]};
            end else begin
                readIssue <= '0;
            end
            beat = randData();
            dqIn <= beat;
            // Driven here, sampled on the next edge
            if (c >= tCl) begin
                k = c - tCl;
                expReadQ.push_back('{data: beat, tag: readAddrQ[k / burstBeats].rank,
                                     valid: 1'b1, last: (k % burstBeats == burstBeats - 1)});
            end
        end
        while (readQ.size() < total) begin
            @(posedge clk);
        end
        idleCycles(4);
        compareValues({name, " beat count"}, 64'(total), 64'(readQ.size()));
        for (int i = 0; i < total; i++) begin
            compareValues({name, " data"}, expReadQ[i].data, readQ[i].data);
            compareValues({name, " tag"}, 64'(expReadQ[i].tag), 64'(readQ[i].tag));
            compareValues({name, " last"}, 64'(expReadQ[i].last), 64'(readQ[i].last));
        end
        compareValues({name, " readAp count"}, 64'(n), 64'(readApQ.size()));
        for (int i = 0; i < n; i++) begin
            compareValues({name, " readAp addr"}, 64'(readAddrQ[i]), 64'(readApQ[i]));
        end
        // Capture edge is one after the sampled issue plus tCl
        compareValues({name, " first beat after capture"}, 64'd1,
                      64'(firstReadCycle >= readIssueCycle + tCl + 2));
    endtask

    task automatic loadBursts(input int n);
        logic [dataWidth-1:0] beat;
        for (int b = 0; b < n; b++) begin
            for (int k = 0; k < burstBeats; k++) begin
                @(posedge clk);
                beat = randData();
                writeIn <= '{data: beat, valid: 1'b1, last: (k == burstBeats - 1)};
                expDqQ.push_back(beat);
            end
        end
        @(posedge clk);
        writeIn <= '0;
    endtask

    task automatic issueWrites(input int n);
        for (int c = 0; c < n * burstBeats; c++) begin
            @(posedge clk);
            if (c % burstBeats == 0) begin
                writeIssue <= '{valid: 1'b1, addr: writeAddrQ[c / burstBeats]};
            end else begin
                writeIssue <= '0;
            end
        end
        @(posedge clk);
        writeIssue <= '0;
    endtask

    task automatic checkWrites(input string name, input int n);
        int lat;
        compareValues({name, " beat count"}, 64'(n * burstBeats), 64'(dqQ.size()));
        for (int i = 0; i < n * burstBeats; i++) begin
            compareValues({name, " DQ data"}, expDqQ[i], dqQ[i]);
        end
        compareValues({name, " burst count"}, 64'(n), 64'(runQ.size()));
        foreach (runQ[i]) begin
            compareValues({name, " oe run"}, 64'(burstBeats), 64'(runQ[i]));
        end
        compareValues({name, " ack count"}, 64'(n), 64'(ackPosQ.size()));
        for (int i = 0; i < n; i++) begin
            compareValues({name, " ack on last beat"}, 64'(burstBeats), 64'(ackPosQ[i]));
            compareValues({name, " writeAp addr"}, 64'(writeAddrQ[i]), 64'(writeApQ[i]));
        end
        lat = firstOeCycle - (writeIssueCycle + 1);
        compareValues({name, " first beat latency"}, 64'd1,
                      64'(lat >= tCwl && lat <= tCwl + 4));
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic resetTest();
        @(negedge clk);
        compareValues("reset readOut.valid", 64'd0, 64'(readOut.valid));
        compareValues("reset oe", 64'd0, 64'(dqOut.oe));
        compareValues("reset readAp", 64'd0, 64'(readAp.valid));
        compareValues("reset writeAp", 64'd0, 64'(writeAp.valid));
        compareValues("reset writeAck", 64'd0, 64'(writeAck));
        compareValues("reset readReady", 64'd1, 64'(readReady));
        compareValues("reset writeReady", 64'd1, 64'(writeReady));
        compareValues("reset modeReady", 64'd1, 64'(modeReady));
    endtask

    task automatic singleReadTest();
        readAddrQ.delete();
        readAddrQ.push_back(randAddr(2'd3));
        readBursts("single read", 1);
    endtask

    task automatic backToBackReadTest();
        readAddrQ.delete();
        readAddrQ.push_back(randAddr(2'd1));
        readAddrQ.push_back(randAddr(2'd2));
        readBursts("back-to-back reads", 2);
    endtask

    task automatic writeTest();
        clearMonitor();
        writeAddrQ.delete();
        writeAddrQ.push_back(randAddr(2'd1));
        loadBursts(1);
        issueWrites(1);
        while (ackPosQ.size() < 1) begin
            @(posedge clk);
        end
        idleCycles(3);
        checkWrites("write", 1);
    endtask

    task automatic backPressureTest();
        clearMonitor();
        writeAddrQ.delete();
        for (int i = 0; i < 3; i++) begin
            writeAddrQ.push_back(randAddr(2'(i)));
        end
        loadBursts(3);
        @(negedge clk);
        compareValues("back-pressure full", 64'd0, 64'(writeReady));
        issueWrites(3);
        while (ackPosQ.size() < 3) begin
            @(posedge clk);
        end
        idleCycles(3);
        @(negedge clk);
        compareValues("back-pressure released", 64'd1, 64'(writeReady));
        checkWrites("back-pressure", 3);
    endtask

    task automatic modeReadyTest();
        readAddrQ.delete();
        readAddrQ.push_back(randAddr(2'd0));
        readBursts("mode read", 1);
        clearMonitor();
        writeAddrQ.delete();
        writeAddrQ.push_back(randAddr(2'd2));
        loadBursts(1);
        issueWrites(1);
        @(negedge clk);
        compareValues("mode busy during write", 64'd0, 64'(modeReady));
        while (ackPosQ.size() < 1) begin
            @(posedge clk);
        end
        idleCycles(30);
        @(negedge clk);
        compareValues("mode ready after idle", 64'd1, 64'(modeReady));
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b0;
        readIssue = '0;
        writeIssue = '0;
        writeIn = '0;
        dqIn = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b1;
        resetTest();
        singleReadTest();
        backToBackReadTest();
        writeTest();
        backPressureTest();
        modeReadyTest();
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
common/phyPkg.sv
hdl/requestWindow.sv
readPath/readCapture.sv
writePath/writeLaunch.sv
hdl/dqBusDriver.sv
hdl/phyController.sv
tests/phyController_props.sv
tests/tbPhyController.sv

//--- run.sh
#!/bin/sh
# Build and run the PHY controller testbench with Verilator
verilator --binary --timing --assert -f files.f --top-module tbPhyController \
    && ./obj_dir/VtbPhyController | tee /dev/stderr | grep -q "Finished with no errors" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
